// ==== logic/lcd_pkg.sv ====
package lcd_pkg;

    typedef logic [15:0] lcd_word_t;

    // one table entry, rs in the top bit of the 17-bit word
    typedef struct packed {
        logic      rs; // 1 = parameter/data, 0 = command
        lcd_word_t data;
    } init_entry_t;

    localparam int    INIT_LEN  = 24;
    localparam int    INIT_AW   = 5;
    localparam string INIT_FILE = "lcd_init.mem";

    localparam int DELAY_INDEX  = 11;  // sleep-out command
    localparam int DELAY_CYCLES = 200; // short pause for simulation

    localparam int WR_LOW_CYCLES  = 2;
    localparam int WR_HIGH_CYCLES = 2;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        ISSUE,
        WAIT_ACK,
        PAUSE,
        DONE
    } seq_state_t;

endpackage

// ==== logic/lcd_wr_if.sv ====
`timescale 1ns/1ps

interface lcd_wr_if;
    import lcd_pkg::*;

    logic        start; // one-cycle request
    init_entry_t entry; // stable from start until done
    logic        done;  // one-cycle completion
    logic        busy;

    modport master (
        output start,
        output entry,
        input  done,
        input  busy
    );

    modport slave (
        input  start,
        input  entry,
        output done,
        output busy
    );

endinterface

// ==== logic/lcd_init_rom.sv ====
`timescale 1ns/1ps

module lcd_init_rom (
    input  logic                        pclk,
    input  logic                        rd_en,
    input  logic [lcd_pkg::INIT_AW-1:0] addr,
    output lcd_pkg::init_entry_t        rd_entry
);
    import lcd_pkg::*;

    logic [$bits(init_entry_t)-1:0] rom_mem [INIT_LEN];

    initial begin
        $readmemh(INIT_FILE, rom_mem);
    end

    always_ff @(posedge pclk) begin
        if (rd_en) begin
            rd_entry <= rom_mem[addr]; // one cycle read latency
        end
    end

    // the sequencer must never walk past the table
    rom_addr_in_range: assert property (
        @(posedge pclk) rd_en |-> (addr < INIT_AW'(INIT_LEN))
    );

endmodule

// ==== logic/lcd_delay_timer.sv ====
`timescale 1ns/1ps

module lcd_delay_timer (
    input  logic pclk,
    input  logic rst_n,
    input  logic load,
    output logic expired
);
    import lcd_pkg::*;

    logic [$clog2(DELAY_CYCLES + 1)-1:0] count;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            count   <= '0;
            expired <= 1'b0;
        end else begin
            expired <= 1'b0;
            if (load) begin
                count <= $bits(count)'(DELAY_CYCLES);
            end else if (count != '0) begin
                count <= count - 1'b1;
                if (count == $bits(count)'(1)) begin
                    expired <= 1'b1; // single pulse, then idle at zero
                end
            end
        end
    end

    // a reload mid-count would silently stretch the pause
    no_load_while_running: assert property (
        @(posedge pclk) disable iff (!rst_n) load |-> (count == '0)
    );

endmodule

// ==== logic/lcd_bus_writer.sv ====
`timescale 1ns/1ps

module lcd_bus_writer (
    input  logic               pclk,
    input  logic               rst_n,
    lcd_wr_if.slave            wr,
    output logic               lcd_cs_n,
    output logic               lcd_rs,
    output logic               lcd_wr_n,
    output lcd_pkg::lcd_word_t lcd_db
);
    import lcd_pkg::*;

    logic [$clog2(WR_LOW_CYCLES + WR_HIGH_CYCLES)-1:0] phase;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            wr.busy  <= 1'b0;
            wr.done  <= 1'b0;
            lcd_cs_n <= 1'b1;
            lcd_wr_n <= 1'b1;
            lcd_rs   <= 1'b0;
            lcd_db   <= '0;
            phase    <= '0;
        end else begin
            wr.done <= 1'b0;
            if (wr.start) begin
                wr.busy  <= 1'b1;
                lcd_cs_n <= 1'b0;
                lcd_wr_n <= 1'b0;
                lcd_rs   <= wr.entry.rs;
                lcd_db   <= wr.entry.data;
                phase    <= '0;
            end else if (wr.busy) begin
                phase <= phase + 1'b1;
                if (phase == $bits(phase)'(WR_LOW_CYCLES - 1)) begin
                    lcd_wr_n <= 1'b1; // panel latches on this rising edge
                end
                // done lands in the last cs_n low cycle
                if (phase == $bits(phase)'(WR_LOW_CYCLES + WR_HIGH_CYCLES - 2)) begin
                    wr.done <= 1'b1;
                    wr.busy <= 1'b0;
                end
            end else begin
                lcd_cs_n <= 1'b1; // rs and db keep the last value
            end
        end
    end

    // requester has to wait for the running cycle to finish
    no_start_while_busy: assert property (
        @(posedge pclk) disable iff (!rst_n) wr.start |-> !wr.busy
    );

endmodule

// ==== logic/lcd_init_seq.sv ====
`timescale 1ns/1ps

module lcd_init_seq (
    input  logic                        pclk,
    input  logic                        rst_n,
    lcd_wr_if.master                    wr,
    output logic                        rom_rd_en,
    output logic [lcd_pkg::INIT_AW-1:0] rom_addr,
    input  lcd_pkg::init_entry_t        rom_entry,
    output logic                        delay_load,
    input  logic                        delay_expired,
    output logic                        init_busy,
    output logic                        init_done
);
    import lcd_pkg::*;

    seq_state_t         state;
    logic [INIT_AW-1:0] addr;
    logic               last_entry;
    logic               at_delay;

    assign last_entry = (addr == INIT_AW'(INIT_LEN - 1));
    assign at_delay   = (addr == INIT_AW'(DELAY_INDEX));

    assign rom_rd_en  = (state == FETCH);
    assign rom_addr   = addr;
    assign wr.start   = (state == ISSUE);
    assign wr.entry   = rom_entry; // rom output holds until the next fetch
    assign delay_load = (state == WAIT_ACK) && wr.done && at_delay;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state     <= IDLE;
            addr      <= '0;
            init_busy <= 1'b1;
            init_done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    addr  <= '0;
                    state <= FETCH;
                end
                FETCH: begin
                    state <= ISSUE;
                end
                ISSUE: begin
                    state <= WAIT_ACK;
                end
                WAIT_ACK: begin
                    if (wr.done) begin
                        if (at_delay) begin
                            state <= PAUSE; // timer loaded by delay_load
                        end else if (last_entry) begin
                            state     <= DONE;
                            init_busy <= 1'b0;
                            init_done <= 1'b1;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= FETCH;
                        end
                    end
                end
                PAUSE: begin
                    if (delay_expired) begin
                        addr  <= addr + 1'b1;
                        state <= FETCH;
                    end
                end
                DONE: begin
                    init_busy <= 1'b0; // parked until the next reset
                    init_done <= 1'b1;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // finished flag excludes busy and never drops again
    done_is_final: assert property (
        @(posedge pclk) disable iff (!rst_n) init_done |-> !init_busy ##1 init_done
    );

endmodule

// ==== logic/lcd_init_top.sv ====
`timescale 1ns/1ps

module lcd_init_top (
    input  logic               pclk,
    input  logic               rst_n,
    output logic               lcd_cs_n,
    output logic               lcd_rs,
    output logic               lcd_wr_n,
    output lcd_pkg::lcd_word_t lcd_db,
    output logic               init_busy,
    output logic               init_done
);
    import lcd_pkg::*;

    logic               rom_rd_en;
    logic [INIT_AW-1:0] rom_addr;
    init_entry_t        rom_entry;
    logic               delay_load;
    logic               delay_expired;

    lcd_wr_if wr_bus ();

    lcd_init_seq lcd_init_seq_inst (
        .pclk          (pclk),
        .rst_n         (rst_n),
        .wr            (wr_bus.master),
        .rom_rd_en     (rom_rd_en),
        .rom_addr      (rom_addr),
        .rom_entry     (rom_entry),
        .delay_load    (delay_load),
        .delay_expired (delay_expired),
        .init_busy     (init_busy),
        .init_done     (init_done)
    );

    lcd_init_rom lcd_init_rom_inst (
        .pclk     (pclk),
        .rd_en    (rom_rd_en),
        .addr     (rom_addr),
        .rd_entry (rom_entry)
    );

    lcd_delay_timer lcd_delay_timer_inst (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .load    (delay_load),
        .expired (delay_expired)
    );

    lcd_bus_writer lcd_bus_writer_inst (
        .pclk     (pclk),
        .rst_n    (rst_n),
        .wr       (wr_bus.slave),
        .lcd_cs_n (lcd_cs_n),
        .lcd_rs   (lcd_rs),
        .lcd_wr_n (lcd_wr_n),
        .lcd_db   (lcd_db)
    );

endmodule

// ==== tb/lcd_init_tb.sv ====
`timescale 1ns/1ps

module lcd_init_tb;
    import lcd_pkg::*;

    logic      pclk;
    logic      rst_n;
    logic      lcd_cs_n;
    logic      lcd_rs;
    logic      lcd_wr_n;
    lcd_word_t lcd_db;
    logic      init_busy;
    logic      init_done;

    logic [$bits(init_entry_t)-1:0] ref_table [INIT_LEN];
    init_entry_t cap_q [$];
    int          idx_q [$];
    init_entry_t cmp_entry;
    int          cmp_idx;

    int          mismatches = 0;
    int          failures = 0;
    int          checks = 0;
    int          writes_seen = 0;
    int          low_cnt = 0;
    int          gap_cnt = 0;
    logic        prev_wr_n = 1'b1;
    logic        prev_cs_n = 1'b1;
    logic        stalled = 1'b0;
    logic [31:0] rng;
    int          abort_after;

    lcd_init_top lcd_init_top_inst (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .lcd_cs_n  (lcd_cs_n),
        .lcd_rs    (lcd_rs),
        .lcd_wr_n  (lcd_wr_n),
        .lcd_db    (lcd_db),
        .init_busy (init_busy),
        .init_done (init_done)
    );

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    initial begin
        $readmemh(INIT_FILE, ref_table);
    end

    function automatic init_entry_t ref_entry(input int idx);
        return init_entry_t'(ref_table[idx]);
    endfunction

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_entry(input string name, input init_entry_t exp, input init_entry_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected rs=%0b db=%04h, got rs=%0b db=%04h",
                     $time, name, exp.rs, exp.data, act.rs, act.data);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // bus monitor, sampled away from the active clock edge
    always @(negedge pclk) begin
        if (!rst_n) begin
            writes_seen = 0;
            low_cnt = 0;
            gap_cnt = 0;
        end else begin
            if (!lcd_wr_n) begin
                check_flag("lcd_cs_n", 1'b0, lcd_cs_n); // strobe only inside chip select
                low_cnt++;
            end
            if (lcd_cs_n) begin
                gap_cnt++;
            end else begin
                if (prev_cs_n && writes_seen > 0) begin
                    check_flag("gap_at_least_delay", (writes_seen - 1 == DELAY_INDEX),
                               (gap_cnt >= DELAY_CYCLES));
                end
                gap_cnt = 0;
            end
            if (!prev_wr_n && lcd_wr_n && !lcd_cs_n) begin // panel latch point
                check_count("lcd_wr_n low cycles", WR_LOW_CYCLES, low_cnt);
                cap_q.push_back('{rs: lcd_rs, data: lcd_db});
                idx_q.push_back(writes_seen);
                writes_seen++;
                low_cnt = 0;
            end
        end
        prev_wr_n = lcd_wr_n;
        prev_cs_n = lcd_cs_n;
    end

    always @(posedge pclk) begin
        while (cap_q.size() > 0) begin
            cmp_entry = cap_q.pop_front();
            cmp_idx = idx_q.pop_front();
            if (cmp_idx >= INIT_LEN) begin
                failures++;
                $display("error at %0t: write %0d goes past the end of the table", $time, cmp_idx);
            end else begin
                check_entry($sformatf("lcd_rs/lcd_db[%0d]", cmp_idx), ref_entry(cmp_idx), cmp_entry);
            end
        end
    end

    task automatic apply_reset();
        @(posedge pclk);
        rst_n <= 1'b0;
        repeat (9) @(posedge pclk);
        @(negedge pclk);
        check_flag("lcd_cs_n", 1'b1, lcd_cs_n);
        check_flag("lcd_wr_n", 1'b1, lcd_wr_n);
        check_flag("init_done", 1'b0, init_done);
        check_flag("init_busy", 1'b1, init_busy);
        @(posedge pclk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_writes(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (!stalled && writes_seen < n) begin
            @(posedge pclk);
            cycles++;
            if (cycles > limit) begin
                stalled = 1'b1;
                failures++;
                $display("error: no write %0d seen within %0d cycles", n, limit);
            end
        end
    endtask

    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        while (!stalled && init_done !== 1'b1) begin
            @(negedge pclk);
            cycles++;
            if (cycles > limit) begin
                stalled = 1'b1;
                failures++;
                $display("error: init_done did not rise within %0d cycles", limit);
            end
        end
    endtask

    task automatic check_full_run();
        wait_done(2000);
        if (!stalled) begin
            check_flag("init_busy", 1'b0, init_busy);
            @(posedge pclk);
            check_count("writes before init_done", INIT_LEN, writes_seen);
            repeat (500) @(posedge pclk); // bus must stay quiet once finished
            check_count("writes after init_done", INIT_LEN, writes_seen);
            @(negedge pclk);
            check_flag("init_done", 1'b1, init_done);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        rng = next_random(32'h1fa5_b2d3);
        abort_after = 1 + int'(rng % 32'(INIT_LEN - 1));
        apply_reset();
        check_full_run();
        apply_reset();
        wait_writes(abort_after, 2000);
        $display("info: reset applied after %0d writes", abort_after);
        apply_reset();
        check_full_run();
        $display("summary: %0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== lcd_init.mem ====
// init table for the LCD power-up sequence, one 17-bit entry per line
// bit 16 = rs (1 = parameter, 0 = command), bits 15:0 = bus word
00001
000CB
10039
1002C
10000
10034
10002
000CF
10000
100C1
10030
00011
0003A
10055
00036
10048
000C0
10023
000C1
10010
000C5
1003E
10028
00029

// ==== lcd_init.f ====
logic/lcd_pkg.sv
logic/lcd_wr_if.sv
logic/lcd_init_rom.sv
logic/lcd_delay_timer.sv
logic/lcd_bus_writer.sv
logic/lcd_init_seq.sv
logic/lcd_init_top.sv
tb/lcd_init_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the LCD init testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lcd_init_tb -f lcd_init.f -o lcd_init_sim

./obj_dir/lcd_init_sim | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
